// File: common/lsu_pkg.sv
/*
 * load/store unit request package
 * core widths, operation and unit encodings, request and control records
 */
package lsu_pkg;

    // ----------------------------------------------------------------------
    // core widths
    // ----------------------------------------------------------------------
    localparam int unsigned XLEN          = 64;
    localparam int unsigned VLEN          = 39;
    localparam int unsigned TRANS_ID_BITS = 3;

    // other codes are not for this unit
    typedef enum logic [1:0] {
        LOAD  = 2'd1,
        STORE = 2'd2
    } fu_t;

    typedef enum logic [3:0] {
        LD  = 4'd0,
        LW  = 4'd1,
        LWU = 4'd2,
        LH  = 4'd3,
        LHU = 4'd4,
        LB  = 4'd5,
        LBU = 4'd6,
        SD  = 4'd7,
        SW  = 4'd8,
        SH  = 4'd9,
        SB  = 4'd10
    } lsu_op_t;

    // exception record, tval holds the faulting virtual address
    typedef struct packed {
        logic [3:0]      cause;
        logic [VLEN-1:0] tval;
        logic            valid;
    } exception_t;

    // ----------------------------------------------------------------------
    // request records
    // ----------------------------------------------------------------------
    // request as issued by the core
    typedef struct packed {
        fu_t                      fu;
        lsu_op_t                  operator;
        logic [XLEN-1:0]          operand_a;
        logic [XLEN-1:0]          operand_b;
        logic [XLEN-1:0]          imm;
        logic [TRANS_ID_BITS-1:0] trans_id;
    } fu_data_t;

    // request after address generation and checks
    typedef struct packed {
        logic                     valid;
        logic [VLEN-1:0]          vaddr;
        logic [XLEN-1:0]          data;
        logic [7:0]               be;
        fu_t                      fu;
        lsu_op_t                  operator;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } lsu_ctrl_t;

endpackage

// File: common/mem_pkg.sv
/*
 * data memory and completion package
 * memory request record, cause codes, load and store completion records
 */
package mem_pkg;

    import lsu_pkg::*;

    // word address width of the memory port
    localparam int unsigned ADDR_BITS = 16;

    // exception causes raised by the unit
    localparam logic [3:0] CAUSE_LD_MISALIGNED   = 4'd4;
    localparam logic [3:0] CAUSE_LD_ACCESS_FAULT = 4'd5;
    localparam logic [3:0] CAUSE_ST_MISALIGNED   = 4'd6;
    localparam logic [3:0] CAUSE_ST_ACCESS_FAULT = 4'd7;

    typedef struct packed {
        logic                 req;
        logic                 we;
        logic [ADDR_BITS-1:0] addr;
        logic [XLEN-1:0]      wdata;
        logic [7:0]           be;
    } mem_req_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        logic [XLEN-1:0]          result;
        exception_t               ex;
    } ld_result_t;

    typedef struct packed {
        logic                     valid;
        logic [TRANS_ID_BITS-1:0] trans_id;
        exception_t               ex;
    } st_result_t;

endpackage

// File: src/addr_gen.sv
/*
 * address generation unit
 * forms the virtual address, byte enables and the address exception
 */
`timescale 1ns/1ns

module addr_gen
    import lsu_pkg::*;
    import mem_pkg::*;
(
    input  fu_data_t  fu_data_i,
    input  logic      valid_i,
    output lsu_ctrl_t ctrl_o
);

    logic [XLEN-1:0] sum;
    logic [VLEN-1:0] vaddr;
    logic            overflow;
    logic            misaligned;
    logic            is_load;
    logic            is_mem;
    logic [1:0]      size;
    logic [7:0]      be;
    exception_t      ex;

    // signed base plus offset
    assign sum   = $unsigned($signed(fu_data_i.imm) + $signed(fu_data_i.operand_a));
    assign vaddr = sum[VLEN-1:0];

    // sv39 style, upper bits must all copy bit VLEN-1
    assign overflow = !((&sum[XLEN-1:VLEN-1]) || !(|sum[XLEN-1:VLEN-1]));

    assign is_load = (fu_data_i.fu == LOAD);
    assign is_mem  = is_load || (fu_data_i.fu == STORE);

    // log2 of transfer size in bytes
    always_comb begin : size_decode
        unique case (fu_data_i.operator)
            LD, SD:      size = 2'd3;
            LW, LWU, SW: size = 2'd2;
            LH, LHU, SH: size = 2'd1;
            default:     size = 2'd0;
        endcase
    end

    // byte enables and alignment from the low address bits
    always_comb begin : be_gen
        unique case (size)
            2'd3: begin
                be         = 8'hff;
                misaligned = (vaddr[2:0] != 3'b000);
            end
            2'd2: begin
                be         = 8'h0f << {vaddr[2], 2'b00};
                misaligned = (vaddr[1:0] != 2'b00);
            end
            2'd1: begin
                be         = 8'h03 << {vaddr[2:1], 1'b0};
                misaligned = vaddr[0];
            end
            default: begin
                // bytes are always aligned
                be         = 8'h01 << vaddr[2:0];
                misaligned = 1'b0;
            end
        endcase
    end

    // access fault wins over misalignment
    always_comb begin : ex_gen
        ex.tval  = vaddr;
        ex.valid = valid_i && is_mem && (overflow || misaligned);
        if (overflow) begin
            ex.cause = is_load ? CAUSE_LD_ACCESS_FAULT : CAUSE_ST_ACCESS_FAULT;
        end else begin
            ex.cause = is_load ? CAUSE_LD_MISALIGNED : CAUSE_ST_MISALIGNED;
        end
    end

    assign ctrl_o = '{
        valid:    valid_i,
        vaddr:    vaddr,
        data:     fu_data_i.operand_b,
        be:       be,
        fu:       fu_data_i.fu,
        operator: fu_data_i.operator,
        trans_id: fu_data_i.trans_id,
        ex:       ex
    };

endmodule

// File: src/lsu_bypass.sv
/*
 * request buffer
 * two-entry queue in front of the load and store units, bypassed when empty
 */
`timescale 1ns/1ns

module lsu_bypass
    import lsu_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  lsu_ctrl_t req_i,
    input  logic      pop_ld_i,
    input  logic      pop_st_i,
    output lsu_ctrl_t ctrl_o,
    output logic      ready_o
);

    lsu_ctrl_t [1:0] mem_q;
    logic            rd_ptr_q;
    logic            wr_ptr_q;
    logic [1:0]      cnt_q;
    logic            empty;
    logic            pop;

    assign empty   = (cnt_q == 2'd0);
    assign ready_o = empty;
    assign pop     = pop_ld_i || pop_st_i;

    // empty buffer hands the new request straight on
    assign ctrl_o = empty ? req_i : mem_q[rd_ptr_q];

    // ----------------------------------------------------------------------
    // storage
    // ----------------------------------------------------------------------
    // every accepted request is written, even if popped at once
    always_ff @(posedge clk_i) begin : store_entry
        if (req_i.valid) begin
            mem_q[wr_ptr_q] <= req_i;
        end
    end

    // pointers and fill count
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctl_regs
        if (!rst_ni) begin
            rd_ptr_q <= 1'b0;
            wr_ptr_q <= 1'b0;
            cnt_q    <= 2'd0;
        end else begin
            if (req_i.valid) begin
                wr_ptr_q <= ~wr_ptr_q;
            end
            if (pop) begin
                rd_ptr_q <= ~rd_ptr_q;
            end
            cnt_q <= cnt_q + 2'(req_i.valid) - 2'(pop);
        end
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------
    no_write_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(req_i.valid && cnt_q == 2'd2))
        else $error("write into a full request buffer");

    // load and store unit never take the same head
    no_double_pop: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(pop_ld_i && pop_st_i))
        else $error("load and store popped together");

endmodule

// File: src/load_unit.sv
/*
 * load unit
 * issues memory reads, then aligns and extends the returned word
 */
`timescale 1ns/1ns

module load_unit
    import lsu_pkg::*;
    import mem_pkg::*;
(
    input  logic            clk_i,
    input  logic            rst_ni,
    input  lsu_ctrl_t       ctrl_i,
    output logic            pop_o,
    output mem_req_t        rd_req_o,
    input  logic [XLEN-1:0] rdata_i,
    output ld_result_t      result_o
);

    typedef enum logic {
        IDLE,
        WAIT
    } state_t;

    state_t                   state_q;
    lsu_op_t                  op_q;
    logic [2:0]               off_q;
    logic [TRANS_ID_BITS-1:0] id_q;
    logic                     ld_valid;
    logic [XLEN-1:0]          shifted;
    logic [XLEN-1:0]          ext_data;

    assign ld_valid = ctrl_i.valid && (ctrl_i.fu == LOAD);

    // take a load only when no read is outstanding
    assign pop_o = ld_valid && (state_q == IDLE);

    // faulting loads never touch memory
    assign rd_req_o = '{
        req:   pop_o && !ctrl_i.ex.valid,
        we:    1'b0,
        addr:  ctrl_i.vaddr[ADDR_BITS+2:3],
        wdata: '0,
        be:    ctrl_i.be
    };

    // ----------------------------------------------------------------------
    // state and outstanding load record
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : fsm
        if (!rst_ni) begin
            state_q <= IDLE;
        end else if (rd_req_o.req) begin
            state_q <= WAIT;
        end else begin
            // data is back one cycle after the read
            state_q <= IDLE;
        end
    end

    always_ff @(posedge clk_i) begin : ld_record
        if (rd_req_o.req) begin
            op_q  <= ctrl_i.operator;
            off_q <= ctrl_i.vaddr[2:0];
            id_q  <= ctrl_i.trans_id;
        end
    end

    // move the addressed bytes to lane zero, then extend
    assign shifted = rdata_i >> {off_q, 3'b000};

    always_comb begin : extend
        unique case (op_q)
            LW:      ext_data = {{32{shifted[31]}}, shifted[31:0]};
            LWU:     ext_data = {32'b0, shifted[31:0]};
            LH:      ext_data = {{48{shifted[15]}}, shifted[15:0]};
            LHU:     ext_data = {48'b0, shifted[15:0]};
            LB:      ext_data = {{56{shifted[7]}}, shifted[7:0]};
            LBU:     ext_data = {56'b0, shifted[7:0]};
            default: ext_data = shifted;
        endcase
    end

    // read completion, or a faulting load in its own cycle
    always_comb begin : completion
        result_o = '0;
        if (state_q == WAIT) begin
            result_o.valid    = 1'b1;
            result_o.trans_id = id_q;
            result_o.result   = ext_data;
        end else if (pop_o && ctrl_i.ex.valid) begin
            result_o.valid    = 1'b1;
            result_o.trans_id = ctrl_i.trans_id;
            result_o.ex       = ctrl_i.ex;
        end
    end

endmodule

// File: src/store_unit.sv
/*
 * store unit
 * lane-aligns write data and completes stores in the cycle they issue
 */
`timescale 1ns/1ns

module store_unit
    import lsu_pkg::*;
    import mem_pkg::*;
(
    input  lsu_ctrl_t  ctrl_i,
    output logic       pop_o,
    output mem_req_t   wr_req_o,
    output st_result_t result_o
);

    logic            st_valid;
    logic [XLEN-1:0] lane_data;

    assign st_valid = ctrl_i.valid && (ctrl_i.fu == STORE);

    // always free for a store
    assign pop_o = st_valid;

    // operand byte 0 goes to the addressed lane
    assign lane_data = ctrl_i.data << {ctrl_i.vaddr[2:0], 3'b000};

    // no write for a faulting store
    assign wr_req_o = '{
        req:   st_valid && !ctrl_i.ex.valid,
        we:    1'b1,
        addr:  ctrl_i.vaddr[ADDR_BITS+2:3],
        wdata: lane_data,
        be:    ctrl_i.be
    };

    assign result_o = '{
        valid:    st_valid,
        trans_id: ctrl_i.trans_id,
        ex:       st_valid ? ctrl_i.ex : '0
    };

endmodule

// File: src/data_sram.sv
/*
 * data memory
 * 64-bit words, byte-enabled writes, reads returned one cycle later
 */
`timescale 1ns/1ns

module data_sram
    import lsu_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned MEM_WORDS = 16
) (
    input  logic            clk_i,
    input  mem_req_t        wr_req_i,
    input  mem_req_t        rd_req_i,
    output logic [XLEN-1:0] rdata_o
);

    localparam int unsigned IDX_BITS = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

    logic [XLEN-1:0]     mem_q [MEM_WORDS];
    logic [IDX_BITS-1:0] wr_idx;
    logic [IDX_BITS-1:0] rd_idx;

    // higher address bits wrap
    assign wr_idx = wr_req_i.addr[IDX_BITS-1:0];
    assign rd_idx = rd_req_i.addr[IDX_BITS-1:0];

    always_ff @(posedge clk_i) begin : mem_port
        if (wr_req_i.req && wr_req_i.we) begin
            for (int b = 0; b < 8; b++) begin
                if (wr_req_i.be[b]) begin
                    mem_q[wr_idx][b*8 +: 8] <= wr_req_i.wdata[b*8 +: 8];
                end
            end
        end
        // same-word write and read returns the old word
        if (rd_req_i.req) begin
            rdata_o <= mem_q[rd_idx];
        end
    end

endmodule

// File: src/result_pipe.sv
/*
 * completion pipeline
 * Depth register stages for one record, plain pass at depth zero
 */
`timescale 1ns/1ns

module result_pipe #(
    parameter int unsigned Depth = 1,
    parameter type         rec_t = logic
) (
    input  logic clk_i,
    input  logic rst_ni,
    input  rec_t d_i,
    output rec_t d_o
);

    if (Depth == 0) begin : g_pass
        assign d_o = d_i;
    end else begin : g_stages
        rec_t stage_q [Depth];

        // cleared stages keep valid low after reset
        always_ff @(posedge clk_i or negedge rst_ni) begin : shift
            if (!rst_ni) begin
                for (int i = 0; i < Depth; i++) begin
                    stage_q[i] <= '0;
                end
            end else begin
                stage_q[0] <= d_i;
                for (int i = 1; i < Depth; i++) begin
                    stage_q[i] <= stage_q[i-1];
                end
            end
        end

        assign d_o = stage_q[Depth-1];
    end

endmodule

// File: src/load_store_unit.sv
/*
 * load/store unit top
 * address generation, request buffer, load and store units,
 * data memory and completion pipelines
 */
`timescale 1ns/1ns

module load_store_unit
    import lsu_pkg::*;
    import mem_pkg::*;
#(
    parameter int unsigned MEM_WORDS        = 16,
    parameter int unsigned LOAD_PIPE_DEPTH  = 1,
    parameter int unsigned STORE_PIPE_DEPTH = 1
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  fu_data_t   fu_data_i,
    input  logic       lsu_valid_i,
    output logic       lsu_ready_o,
    output ld_result_t load_o,
    output st_result_t store_o
);

    lsu_ctrl_t       lsu_req;
    lsu_ctrl_t       lsu_ctrl;
    logic            pop_ld;
    logic            pop_st;
    mem_req_t        rd_req;
    mem_req_t        wr_req;
    logic [XLEN-1:0] rdata;
    ld_result_t      ld_result;
    st_result_t      st_result;

    // ----------------------------------------------------------------------
    // request path
    // ----------------------------------------------------------------------
    // only accepted requests count as valid
    addr_gen u_addr_gen (
        .fu_data_i (fu_data_i),
        .valid_i   (lsu_valid_i && lsu_ready_o),
        .ctrl_o    (lsu_req)
    );

    lsu_bypass u_lsu_bypass (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .req_i    (lsu_req),
        .pop_ld_i (pop_ld),
        .pop_st_i (pop_st),
        .ctrl_o   (lsu_ctrl),
        .ready_o  (lsu_ready_o)
    );

    // both units watch the head, each acts on its own fu
    load_unit u_load_unit (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .ctrl_i   (lsu_ctrl),
        .pop_o    (pop_ld),
        .rd_req_o (rd_req),
        .rdata_i  (rdata),
        .result_o (ld_result)
    );

    store_unit u_store_unit (
        .ctrl_i   (lsu_ctrl),
        .pop_o    (pop_st),
        .wr_req_o (wr_req),
        .result_o (st_result)
    );

    data_sram #(
        .MEM_WORDS (MEM_WORDS)
    ) u_data_sram (
        .clk_i    (clk_i),
        .wr_req_i (wr_req),
        .rd_req_i (rd_req),
        .rdata_o  (rdata)
    );

    // ----------------------------------------------------------------------
    // completion pipelines
    // ----------------------------------------------------------------------
    result_pipe #(
        .Depth (LOAD_PIPE_DEPTH),
        .rec_t (ld_result_t)
    ) u_load_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (ld_result),
        .d_o    (load_o)
    );

    result_pipe #(
        .Depth (STORE_PIPE_DEPTH),
        .rec_t (st_result_t)
    ) u_store_pipe (
        .clk_i  (clk_i),
        .rst_ni (rst_ni),
        .d_i    (st_result),
        .d_o    (store_o)
    );

endmodule

// File: test/tb_lsu.sv
/*
 * load/store unit testbench
 * random requests against a memory model, completions checked in order
 */
`timescale 1ns/1ns

module tb_lsu
    import lsu_pkg::*;
    import mem_pkg::*;
();

    localparam int MEM_WORDS  = 16;
    localparam int IDX_BITS   = $clog2(MEM_WORDS);
    localparam int ADDR_OK    = 0;
    localparam int ADDR_MISAL = 1;
    localparam int ADDR_OVF   = 2;

    logic       clk_i;
    logic       rst_ni;
    fu_data_t   fu_data;
    logic       lsu_valid;
    logic       lsu_ready;
    ld_result_t load_res;
    st_result_t store_res;

    // reference model
    logic [63:0] model_mem [MEM_WORDS];
    ld_result_t  exp_ld_q [$];
    st_result_t  exp_st_q [$];
    logic [2:0]  next_id;
    int unsigned ready_drops;

    load_store_unit u_load_store_unit (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .fu_data_i   (fu_data),
        .lsu_valid_i (lsu_valid),
        .lsu_ready_o (lsu_ready),
        .load_o      (load_res),
        .store_o     (store_res)
    );

    always #10 clk_i = ~clk_i;

    // ----------------------------------------------------------------------
    // failure handling and checks
    // ----------------------------------------------------------------------
    task automatic stop_run(string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1, "simulation stopped");
    endtask

    task automatic compare_value(string what, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            stop_run($sformatf("error at %0t ns: %s is %h, expected %h",
                               $time, what, got, exp));
        end
    endtask

    task automatic check_idle();
        compare_value("lsu_ready_o in reset", 64'(lsu_ready), 64'd1);
        compare_value("load valid in reset", 64'(load_res.valid), 64'd0);
        compare_value("store valid in reset", 64'(store_res.valid), 64'd0);
    endtask

    // ----------------------------------------------------------------------
    // model rules
    // ----------------------------------------------------------------------
    function automatic int op_bytes(lsu_op_t op);
        case (op)
            LD, SD:      return 8;
            LW, LWU, SW: return 4;
            LH, LHU, SH: return 2;
            default:     return 1;
        endcase
    endfunction

    // pick bytes from the word, then sign or zero extend
    function automatic logic [63:0] load_value(lsu_op_t op, logic [63:0] word, int off);
        int          n;
        logic [63:0] val;
        n   = op_bytes(op);
        val = '0;
        for (int b = 0; b < n; b++) begin
            val[b*8 +: 8] = word[(off + b)*8 +: 8];
        end
        if ((op == LW || op == LH || op == LB) && val[n*8-1]) begin
            for (int b = n; b < 8; b++) begin
                val[b*8 +: 8] = 8'hff;
            end
        end
        return val;
    endfunction

    // upper bits copy bit 38 unless an overflow is wanted
    function automatic logic [63:0] make_addr(int kind, int nbytes);
        logic [63:0] sum;
        int          off;
        int          k;
        sum        = {$urandom, $urandom};
        sum[63:38] = {26{sum[38]}};
        off        = $urandom_range(0, 7);
        if (kind == ADDR_OK) begin
            off = off & ~(nbytes - 1);
        end else if (kind == ADDR_MISAL) begin
            // odd offset, only bytes stay aligned
            off = off | 1;
        end
        sum[2:0] = 3'(off);
        if (kind == ADDR_OVF) begin
            k      = 39 + $urandom_range(0, 24);
            sum[k] = ~sum[k];
        end
        return sum;
    endfunction

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic idle_cycle();
        @(posedge clk_i);
        #2;
        lsu_valid = 1'b0;
    endtask

    // offer one request, hold it until accepted, then update the model
    task automatic send_request(lsu_op_t op, logic [63:0] sum, logic [63:0] data);
        fu_data_t            req;
        ld_result_t          exp_ld;
        st_result_t          exp_st;
        logic [63:0]         base;
        logic                store;
        logic                ovf;
        logic                misal;
        int                  nbytes;
        int                  off;
        logic [IDX_BITS-1:0] idx;
        int                  waited;
        store  = (op == SD || op == SW || op == SH || op == SB);
        nbytes = op_bytes(op);
        off    = int'(sum[2:0]);
        idx    = sum[IDX_BITS+2:3];
        ovf    = (sum[63:38] != {26{sum[38]}});
        misal  = (off % nbytes) != 0;
        base   = {$urandom, $urandom};
        req.fu        = store ? STORE : LOAD;
        req.operator  = op;
        req.operand_a = base;
        req.operand_b = data;
        req.imm       = sum - base;
        req.trans_id  = next_id;
        @(posedge clk_i);
        #2;
        fu_data   = req;
        lsu_valid = 1'b1;
        @(negedge clk_i);
        waited = 0;
        while (!lsu_ready) begin
            if (waited == 20) begin
                stop_run("timeout: request was not accepted within 20 cycles");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        // accepted at the coming edge
        exp_ld          = '0;
        exp_ld.valid    = 1'b1;
        exp_ld.trans_id = next_id;
        exp_ld.ex.valid = ovf || misal;
        exp_ld.ex.tval  = sum[VLEN-1:0];
        exp_st          = '0;
        exp_st.valid    = 1'b1;
        exp_st.trans_id = next_id;
        exp_st.ex       = exp_ld.ex;
        if (store) begin
            exp_st.ex.cause = ovf ? CAUSE_ST_ACCESS_FAULT : CAUSE_ST_MISALIGNED;
            if (!exp_st.ex.valid) begin
                for (int b = 0; b < nbytes; b++) begin
                    model_mem[idx][(off + b)*8 +: 8] = data[b*8 +: 8];
                end
            end
            exp_st_q.push_back(exp_st);
        end else begin
            exp_ld.ex.cause = ovf ? CAUSE_LD_ACCESS_FAULT : CAUSE_LD_MISALIGNED;
            if (!exp_ld.ex.valid) begin
                exp_ld.result = load_value(op, model_mem[idx], off);
            end
            exp_ld_q.push_back(exp_ld);
        end
        next_id = next_id + 3'd1;
    endtask

    // percentages pick gaps, stores and address kinds
    task automatic random_traffic(int count, int store_pct, int misal_pct, int ovf_pct,
                                  int gap_pct);
        lsu_op_t op;
        int      r;
        int      kind;
        for (int i = 0; i < count; i++) begin
            if ($urandom_range(0, 99) < gap_pct) begin
                idle_cycle();
            end
            if ($urandom_range(0, 99) < store_pct) begin
                op = lsu_op_t'($urandom_range(7, 10));
            end else begin
                op = lsu_op_t'($urandom_range(0, 6));
            end
            r    = $urandom_range(0, 99);
            kind = (r < ovf_pct) ? ADDR_OVF : (r < ovf_pct + misal_pct) ? ADDR_MISAL : ADDR_OK;
            send_request(op, make_addr(kind, op_bytes(op)), {$urandom, $urandom});
        end
    endtask

    // ----------------------------------------------------------------------
    // completion monitor, sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk_i) begin : monitor
        ld_result_t exp_ld;
        st_result_t exp_st;
        if (rst_ni) begin
            if (!lsu_ready) begin
                ready_drops++;
            end
            if (load_res.valid) begin
                if (exp_ld_q.size() == 0) begin
                    stop_run("a load completed with no load outstanding");
                end else begin
                    exp_ld = exp_ld_q.pop_front();
                    compare_value("load trans_id", 64'(load_res.trans_id),
                                  64'(exp_ld.trans_id));
                    compare_value("load ex.valid", 64'(load_res.ex.valid),
                                  64'(exp_ld.ex.valid));
                    if (exp_ld.ex.valid) begin
                        compare_value("load cause", 64'(load_res.ex.cause),
                                      64'(exp_ld.ex.cause));
                        compare_value("load tval", 64'(load_res.ex.tval),
                                      64'(exp_ld.ex.tval));
                    end else begin
                        compare_value("load result", load_res.result, exp_ld.result);
                    end
                end
            end
            if (store_res.valid) begin
                if (exp_st_q.size() == 0) begin
                    stop_run("a store completed with no store outstanding");
                end else begin
                    exp_st = exp_st_q.pop_front();
                    compare_value("store trans_id", 64'(store_res.trans_id),
                                  64'(exp_st.trans_id));
                    compare_value("store ex.valid", 64'(store_res.ex.valid),
                                  64'(exp_st.ex.valid));
                    if (exp_st.ex.valid) begin
                        compare_value("store cause", 64'(store_res.ex.cause),
                                      64'(exp_st.ex.cause));
                        compare_value("store tval", 64'(store_res.ex.tval),
                                      64'(exp_st.ex.tval));
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------
    initial begin : main
        int waited;
        void'($urandom(32'hd0429dc6));
        clk_i       = 1'b0;
        rst_ni      = 1'b0;
        lsu_valid   = 1'b0;
        fu_data     = '0;
        next_id     = '0;
        ready_drops = 0;
        for (int c = 0; c < 10; c++) begin
            @(negedge clk_i);
            check_idle();
        end
        @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(negedge clk_i);
        check_idle();

        // every word gets a known doubleword
        for (int w = 0; w < MEM_WORDS; w++) begin
            send_request(SD, 64'(w) << 3, {$urandom, $urandom});
        end
        random_traffic(40, 100, 0, 0, 30);
        random_traffic(150, 0, 0, 0, 30);
        // faults mixed in
        random_traffic(200, 40, 15, 15, 30);
        // back to back, ready has to drop
        random_traffic(30, 0, 0, 0, 0);
        random_traffic(100, 50, 10, 10, 0);
        // read back the whole memory
        for (int w = 0; w < MEM_WORDS; w++) begin
            send_request(LD, 64'(w) << 3, '0);
        end
        idle_cycle();

        waited = 0;
        while (exp_ld_q.size() != 0 || exp_st_q.size() != 0) begin
            if (waited == 50) begin
                stop_run("timeout: completions still outstanding after 50 cycles");
            end else begin
                waited++;
                @(negedge clk_i);
            end
        end
        // a few quiet cycles catch stray completions
        repeat (5) @(negedge clk_i);
        compare_value("lsu_ready_o dropped", 64'(ready_drops != 0), 64'd1);
        $display("=== PASS ===");
        $finish;
    end

endmodule

// File: all.f
common/lsu_pkg.sv
common/mem_pkg.sv
src/addr_gen.sv
src/lsu_bypass.sv
src/load_unit.sv
src/store_unit.sv
src/data_sram.sv
src/result_pipe.sv
src/load_store_unit.sv
test/tb_lsu.sv

// File: Makefile
# Verilator build and run of the load/store unit testbench

SIM  := obj_dir/Vtb_lsu
SRCS := $(shell cat all.f)

.PHONY: all run clean

all: run

$(SIM): all.f $(SRCS)
	verilator --binary --timing --assert --top-module tb_lsu -f all.f -o Vtb_lsu

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf obj_dir
